// File: source/smc_settings.svh
`ifndef SMC_SETTINGS_SVH
`define SMC_SETTINGS_SVH

// Extra clocks each external cycle is held, 0 to 7
`define SMC_WAIT_STATES 1

// Wait counter width, wide enough for 7 wait states
`define SMC_WAIT_W 3

// Internal and external address width
`define SMC_ADDR_W 32

// Most external cycles one access can need
`define SMC_MAX_CYCLES 4

// Random accesses issued in a testbench run
`define SMC_NUM_ACCESSES 60

`endif

// File: source/smc_size_pkg.sv
package smc_size_pkg;

   //------------------------------
   // Internal transfer size
   //------------------------------
   // Code 2'b11 has no meaning
   typedef enum logic [1:0]
   {
      xsiz_8  = 2'b00,  // Byte
      xsiz_16 = 2'b01,  // Halfword
      xsiz_32 = 2'b10   // Word
   } smc_xfer_size_t;

   //------------------------------
   // External bus width
   //------------------------------
   typedef enum logic [1:0]
   {
      bsiz_8  = 2'b00,  // 8 bit memory
      bsiz_16 = 2'b01,  // 16 bit memory
      bsiz_32 = 2'b10   // 32 bit memory
   } smc_bus_size_t;

endpackage

// File: source/smc_state_pkg.sv
package smc_state_pkg;

   //------------------------------
   // Cycle state machine states
   //------------------------------
   typedef enum logic
   {
      st_idle = 1'b0,  // Waiting for an access
      st_rw   = 1'b1   // External cycles running
   } smc_state_t;

endpackage

// File: source/smc_state.sv
`timescale 1ns/1ps
`include "smc_settings.svh"

module smc_state
(
   input  logic                          sys_clk1,       // System clock
   input  logic                          n_sys_reset1,   // Async reset, active low
   input  logic                          valid_access,   // Start of new access
   input  smc_size_pkg::smc_xfer_size_t  xfer_size,      // Live transfer size
   input  smc_size_pkg::smc_bus_size_t   bus_size,       // Live bus width
   output smc_size_pkg::smc_xfer_size_t  v_xfer_size,    // Validated transfer size
   output smc_size_pkg::smc_bus_size_t   v_bus_size,     // Validated bus width
   output logic [1:0]                    r_num_access,   // External cycles left
   output logic                          smc_done,       // Last clock of a cycle
   output smc_state_pkg::smc_state_t     smc_nextstate,  // Next cycle state
   output logic                          busy            // Access in progress
);

   import smc_size_pkg::*;
   import smc_state_pkg::*;

   smc_state_t               r_state;      // Current state
   smc_xfer_size_t           r_xfer_size;  // Held transfer size
   smc_bus_size_t            r_bus_size;   // Held bus width
   logic [`SMC_WAIT_W-1:0]   r_wait_cnt;   // Clocks spent in this cycle
   logic [1:0]               num_access;   // Total cycles minus one
   logic                     accept;       // Start honoured this cycle

   // Only idle takes a new access
   assign accept = valid_access && (r_state == st_idle);
   assign busy   = (r_state == st_rw);

   //------------------------------
   // Size hold
   //------------------------------
   always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
   begin
      if (!n_sys_reset1)
      begin
         r_xfer_size <= xsiz_8;
         r_bus_size  <= bsiz_8;
      end
      else if (accept)
      begin
         r_xfer_size <= xfer_size;
         r_bus_size  <= bus_size;
      end
   end

   assign v_xfer_size = accept ? xfer_size : r_xfer_size;  // Live on start
   assign v_bus_size  = accept ? bus_size  : r_bus_size;

   //------------------------------
   // Access counter
   //------------------------------
   always_comb
   begin
      num_access = 2'd0;                       // One cycle unless split
      if (v_xfer_size == xsiz_32 && v_bus_size == bsiz_8)
         num_access = 2'd3;                    // Four byte cycles
      else if (v_xfer_size == xsiz_32 && v_bus_size == bsiz_16)
         num_access = 2'd1;                    // Two halfword cycles
      else if (v_xfer_size == xsiz_16 && v_bus_size == bsiz_8)
         num_access = 2'd1;                    // Two byte cycles
   end

   always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
   begin
      if (!n_sys_reset1)
         r_num_access <= 2'd0;
      else if (accept)
         r_num_access <= num_access;
      else if (smc_done && (r_num_access != 2'd0))
         r_num_access <= r_num_access - 2'd1;  // Count down per cycle
   end

   //------------------------------
   // Wait counter
   //------------------------------
   // Done once the wait states have run out
   assign smc_done = (r_state == st_rw) &&
                     (r_wait_cnt == `SMC_WAIT_W'(`SMC_WAIT_STATES));

   always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
   begin
      if (!n_sys_reset1)
         r_wait_cnt <= '0;
      else if (accept || smc_done)
         r_wait_cnt <= '0;                     // Fresh external cycle
      else if (r_state == st_rw)
         r_wait_cnt <= r_wait_cnt + 1'b1;
   end

   //------------------------------
   // Cycle state machine
   //------------------------------
   always_comb
   begin
      smc_nextstate = r_state;
      case (r_state)
         st_idle:
            if (valid_access)
               smc_nextstate = st_rw;
         st_rw:
            if (smc_done && (r_num_access == 2'd0))
               smc_nextstate = st_idle;        // Last cycle finished
         default:
            smc_nextstate = st_idle;
      endcase
   end

   always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
   begin
      if (!n_sys_reset1)
         r_state <= st_idle;
      else
         r_state <= smc_nextstate;
   end

endmodule

// File: source/smc_addr.sv
`timescale 1ns/1ps
`include "smc_settings.svh"

module smc_addr
(
   input  logic                          sys_clk1,       // System clock
   input  logic                          n_sys_reset1,   // Async reset, active low
   input  logic                          valid_access,   // Start of new access
   input  logic [1:0]                    r_num_access,   // External cycles left
   input  smc_size_pkg::smc_bus_size_t   v_bus_size,     // Validated bus width
   input  smc_size_pkg::smc_xfer_size_t  v_xfer_size,    // Validated transfer size
   input  logic                          cs,             // Internal chip select
   input  logic [`SMC_ADDR_W-1:0]        addr,           // Internal byte address
   input  logic                          smc_done,       // End of an external cycle
   input  smc_state_pkg::smc_state_t     smc_nextstate,  // Next cycle state
   output logic [`SMC_ADDR_W-1:0]        smc_addr,       // External address
   output logic [3:0]                    smc_n_be,       // External byte enables
   output logic                          smc_n_cs        // External chip select
);

   import smc_size_pkg::*;
   import smc_state_pkg::*;

   smc_state_t   r_state;    // Tracks the state machine's current state
   logic         accept;     // Start honoured this cycle
   logic         r_cs;       // Stored chip select
   logic         v_cs;       // Validated chip select
   logic [1:0]   r_addr;     // Stored low address bits
   logic [1:0]   v_addr;     // Validated low address bits
   logic [1:0]   first_lsb;  // Low bits for the first external cycle
   logic [1:0]   next_lsb;   // Low bits after each smc_done
   logic [3:0]   n_be;       // Unregistered byte enables

   //------------------------------
   // State copy and access start
   //------------------------------
   always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
   begin
      if (!n_sys_reset1)
         r_state <= st_idle;
      else
         r_state <= smc_nextstate;  // Same value as the state machine
   end

   // Pulses while busy are dropped
   assign accept = valid_access && (r_state == st_idle);

   //------------------------------
   // Chip select and address store
   //------------------------------
   always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
   begin
      if (!n_sys_reset1)
      begin
         r_cs   <= 1'b0;
         r_addr <= 2'b00;
      end
      else if (accept)
      begin
         r_cs   <= cs;
         r_addr <= addr[1:0];
      end
   end

   assign v_cs   = accept ? cs : r_cs;          // Live in the start cycle
   assign v_addr = accept ? addr[1:0] : r_addr;

   //------------------------------
   // Low address bits
   //------------------------------
   // Little endian, narrow buses walk down to offset 0
   always_comb
   begin
      case (v_xfer_size)
         xsiz_32:
            case (v_bus_size)
               bsiz_8:  first_lsb = 2'b11;             // Top byte first
               bsiz_16: first_lsb = 2'b10;             // Upper half first
               default: first_lsb = 2'b00;
            endcase
         xsiz_16:
            if (v_bus_size == bsiz_8)
               first_lsb = {addr[1], 1'b1};            // Upper byte of the half
            else
               first_lsb = {addr[1], 1'b0};
         default:
            first_lsb = addr[1:0];                     // Byte goes as addressed
      endcase
   end

   // Following cycles, indexed by the remaining count
   always_comb
   begin
      case (v_xfer_size)
         xsiz_32:
            if (v_bus_size == bsiz_8)
               case (r_num_access)
                  2'b11:   next_lsb = 2'b10;
                  2'b10:   next_lsb = 2'b01;
                  2'b01:   next_lsb = 2'b00;
                  default: next_lsb = 2'b11;           // Past the last byte
               endcase
            else
               next_lsb = 2'b00;                       // Lower half
         xsiz_16:
            next_lsb = {r_addr[1], 1'b0};              // Lower byte of the half
         default:
            next_lsb = r_addr;
      endcase
   end

   always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
   begin
      if (!n_sys_reset1)
         smc_addr <= '0;
      else if (accept)
      begin
         smc_addr[`SMC_ADDR_W-1:2] <= addr[`SMC_ADDR_W-1:2];  // Word part held
         smc_addr[1:0]             <= first_lsb;
      end
      else if (smc_done)
         smc_addr[1:0] <= next_lsb;                   // Step to the next cycle
   end

   //------------------------------
   // Byte enables, active low
   //------------------------------
   always_comb
   begin
      n_be = 4'b1111;                                  // Deselected
      if (v_cs)
      begin
         case (v_xfer_size)
            xsiz_8:
               case (v_bus_size)
                  bsiz_32: n_be = ~(4'b0001 << v_addr);        // Lane by offset
                  bsiz_16: n_be = v_addr[0] ? 4'b1101 : 4'b1110;
                  bsiz_8:  n_be = 4'b1110;
                  default: n_be = 4'b1111;
               endcase
            xsiz_16:
               case (v_bus_size)
                  bsiz_32: n_be = v_addr[1] ? 4'b0011 : 4'b1100;
                  bsiz_16: n_be = 4'b1100;
                  bsiz_8:  n_be = 4'b1110;
                  default: n_be = 4'b1111;
               endcase
            xsiz_32:
               case (v_bus_size)
                  bsiz_32: n_be = 4'b0000;             // Whole word at once
                  bsiz_16: n_be = 4'b1100;
                  bsiz_8:  n_be = 4'b1110;
                  default: n_be = 4'b1111;
               endcase
            default:
               n_be = 4'b1111;                         // Unused size code
         endcase
      end
   end

   //------------------------------
   // Registered chip select and enables
   //------------------------------
   always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
   begin
      if (!n_sys_reset1)
      begin
         smc_n_cs <= 1'b1;
         smc_n_be <= 4'hF;
      end
      else if (smc_nextstate == st_rw)
      begin
         smc_n_cs <= ~v_cs;
         smc_n_be <= n_be;
      end
      else
      begin
         smc_n_cs <= 1'b1;   // Bus released
         smc_n_be <= 4'hF;
      end
   end

endmodule

// File: source/smc_lite.sv
`timescale 1ns/1ps
`include "smc_settings.svh"

module smc_lite
(
   input  logic                          sys_clk1,      // System clock
   input  logic                          n_sys_reset1,  // Async reset, active low
   input  logic                          valid_access,  // Access start pulse
   input  logic                          cs,            // Internal chip select
   input  logic [`SMC_ADDR_W-1:0]        addr,          // Internal byte address
   input  smc_size_pkg::smc_xfer_size_t  xfer_size,     // Transfer size
   input  smc_size_pkg::smc_bus_size_t   bus_size,      // External bus width
   output logic [`SMC_ADDR_W-1:0]        smc_addr,      // External address
   output logic                          smc_n_cs,      // Chip select, active low
   output logic [3:0]                    smc_n_be,      // Byte enables, active low
   output logic                          busy           // Access in progress
);

   import smc_size_pkg::*;
   import smc_state_pkg::*;

   smc_xfer_size_t   v_xfer_size;    // Validated transfer size
   smc_bus_size_t    v_bus_size;     // Validated bus width
   logic [1:0]       r_num_access;   // External cycles left
   logic             smc_done;       // End of an external cycle
   smc_state_t       smc_nextstate;  // Next cycle state

   // Cycle counting and size hold
   smc_state u_state
   (
      .sys_clk1      (sys_clk1),
      .n_sys_reset1  (n_sys_reset1),
      .valid_access  (valid_access),
      .xfer_size     (xfer_size),
      .bus_size      (bus_size),
      .v_xfer_size   (v_xfer_size),
      .v_bus_size    (v_bus_size),
      .r_num_access  (r_num_access),
      .smc_done      (smc_done),
      .smc_nextstate (smc_nextstate),
      .busy          (busy)
   );

   // External address, chip select and enables
   smc_addr u_addr
   (
      .sys_clk1      (sys_clk1),
      .n_sys_reset1  (n_sys_reset1),
      .valid_access  (valid_access),
      .r_num_access  (r_num_access),
      .v_bus_size    (v_bus_size),
      .v_xfer_size   (v_xfer_size),
      .cs            (cs),
      .addr          (addr),
      .smc_done      (smc_done),
      .smc_nextstate (smc_nextstate),
      .smc_addr      (smc_addr),
      .smc_n_be      (smc_n_be),
      .smc_n_cs      (smc_n_cs)
   );

endmodule

// File: testbench/smc_clk_gen.sv
`timescale 1ns/1ps

module smc_clk_gen
(
   output logic sys_clk1,      // Testbench clock, 4 ns period
   output logic n_sys_reset1   // Reset, low for the first 3 clocks
);

   initial
   begin
      sys_clk1     = 1'b0;
      n_sys_reset1 = 1'b0;
      repeat (3) @(posedge sys_clk1);
      @(negedge sys_clk1);
      n_sys_reset1 = 1'b1;   // Release between rising edges
   end

   always #2 sys_clk1 = ~sys_clk1;

endmodule

// File: testbench/tb_smc_lite.sv
`timescale 1ns/1ps
`include "smc_settings.svh"

module tb_smc_lite;

   import smc_size_pkg::*;

   localparam int CYC_LEN = `SMC_WAIT_STATES + 1;  // Clocks per external cycle
   localparam int TIMEOUT_CYCLES = `SMC_NUM_ACCESSES * `SMC_MAX_CYCLES * CYC_LEN + 50;

   logic                   sys_clk1;
   logic                   n_sys_reset1;
   logic                   valid_access;
   logic                   cs;
   logic [`SMC_ADDR_W-1:0] addr;
   smc_xfer_size_t         xfer_size;
   smc_bus_size_t          bus_size;
   logic [`SMC_ADDR_W-1:0] smc_addr;
   logic                   smc_n_cs;
   logic [3:0]             smc_n_be;
   logic                   busy;

   // Access as issued, written by the stimulus
   logic                   acc_cs;
   logic [`SMC_ADDR_W-1:0] acc_addr;
   smc_xfer_size_t         acc_xfer;
   smc_bus_size_t          acc_bus;
   string                  test_name;
   // Copy taken by the checker when busy rises
   logic                   chk_cs;
   logic [`SMC_ADDR_W-1:0] chk_addr;
   smc_xfer_size_t         chk_xfer;
   smc_bus_size_t          chk_bus;
   string                  chk_name;
   int                     chk_n;       // Expected external cycles
   logic [35:0]            exp_cycle;   // {address, enables}
   int                     busy_cnt;    // Clocks of busy in this access
   int                     issued_cnt;
   int                     started_cnt;
   int                     done_cnt;
   int                     cycle_cnt;
   logic [31:0]            rnd_state;
   int                     xi;
   int                     bi;
   int                     off;

   smc_clk_gen u_clk_gen (.sys_clk1(sys_clk1), .n_sys_reset1(n_sys_reset1));

   smc_lite u_smc_lite
   (
      .sys_clk1     (sys_clk1),
      .n_sys_reset1 (n_sys_reset1),
      .valid_access (valid_access),
      .cs           (cs),
      .addr         (addr),
      .xfer_size    (xfer_size),
      .bus_size     (bus_size),
      .smc_addr     (smc_addr),
      .smc_n_cs     (smc_n_cs),
      .smc_n_be     (smc_n_be),
      .busy         (busy)
   );

   //------------------------------
   // Helpers and reference model
   //------------------------------
   task automatic report_error(input string line);
      $display("%s", line);
      $display("tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic int xfer_bytes(input smc_xfer_size_t x);
      case (x)
         xsiz_8:  return 1;
         xsiz_16: return 2;
         default: return 4;
      endcase
   endfunction

   function automatic int bus_bytes(input smc_bus_size_t b);
      case (b)
         bsiz_8:  return 1;
         bsiz_16: return 2;
         default: return 4;
      endcase
   endfunction

   // Beats needed when the transfer is wider than the bus
   function automatic int expect_count(input smc_xfer_size_t x, input smc_bus_size_t b);
      return (xfer_bytes(x) > bus_bytes(b)) ? xfer_bytes(x) / bus_bytes(b) : 1;
   endfunction

   // Returns {address, active low enables} for external cycle idx
   function automatic logic [35:0] expect_cycle
   (
      input logic                   a_cs,
      input logic [`SMC_ADDR_W-1:0] a_addr,
      input smc_xfer_size_t         a_xfer,
      input smc_bus_size_t          a_bus,
      input int                     idx
   );
      int         xb;
      int         bb;
      int         n;
      int         a_off;
      int         low;
      int         lane_w;
      int         mask;
      logic [3:0] be;
      xb     = xfer_bytes(a_xfer);
      bb     = bus_bytes(a_bus);
      n      = expect_count(a_xfer, a_bus);
      a_off  = a_addr[1:0];
      low    = (a_off & ~(xb - 1)) + (n - 1 - idx) * bb;   // Highest beat first
      lane_w = (xb < bb) ? xb : bb;
      mask   = ((1 << lane_w) - 1) << ((a_off % bb) & ~(lane_w - 1));
      be     = a_cs ? ~mask[3:0] : 4'hF;
      return {a_addr[`SMC_ADDR_W-1:2], low[1:0], be};
   endfunction

   //------------------------------
   // Checker, samples on rising edges
   //------------------------------
   always @(posedge sys_clk1)
   begin
      if (n_sys_reset1 && busy)
      begin
         if (busy_cnt == 0)
         begin
            chk_cs   = acc_cs;               // Latch the running access
            chk_addr = acc_addr;
            chk_xfer = acc_xfer;
            chk_bus  = acc_bus;
            chk_name = test_name;
            chk_n    = expect_count(acc_xfer, acc_bus);
            started_cnt++;
            assert (started_cnt <= issued_cnt)
               else report_error("DUT started an access that was never issued");
         end
         assert (busy_cnt < chk_n * CYC_LEN)
            else report_error($sformatf("Access in %s stayed busy too long", chk_name));
         exp_cycle = expect_cycle(chk_cs, chk_addr, chk_xfer, chk_bus, busy_cnt / CYC_LEN);
         assert (smc_n_cs === ~chk_cs)
            else report_error($sformatf("FAIL %s: smc_n_cs expected %b actual %b",
                                        chk_name, ~chk_cs, smc_n_cs));
         assert (smc_addr === exp_cycle[35:4])
            else report_error($sformatf("FAIL %s: smc_addr expected %h actual %h",
                                        chk_name, exp_cycle[35:4], smc_addr));
         assert (smc_n_be === exp_cycle[3:0])
            else report_error($sformatf("FAIL %s: smc_n_be expected %h actual %h",
                                        chk_name, exp_cycle[3:0], smc_n_be));
         busy_cnt++;
      end
      else if (n_sys_reset1)
      begin
         assert (smc_n_cs === 1'b1 && smc_n_be === 4'hF)
            else report_error($sformatf("FAIL idle: n_cs/n_be expected 1/f actual %b/%h",
                                        smc_n_cs, smc_n_be));
         if (busy_cnt != 0)
         begin
            // Access just ended, check its length
            assert (busy_cnt == chk_n * CYC_LEN)
               else report_error($sformatf("FAIL %s: busy clocks expected %0d actual %0d",
                                           chk_name, chk_n * CYC_LEN, busy_cnt));
            done_cnt++;
            busy_cnt = 0;
         end
      end
   end

   // Run limit
   always @(posedge sys_clk1)
   begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES)
         report_error("The run timed out before all accesses finished");
   end

   //------------------------------
   // Stimulus, driven on falling edges
   //------------------------------
   task automatic issue_access
   (
      input logic                   a_cs,
      input logic [`SMC_ADDR_W-1:0] a_addr,
      input smc_xfer_size_t         a_xfer,
      input smc_bus_size_t          a_bus
   );
      while (busy)
         @(negedge sys_clk1);                // First idle cycle, back to back
      acc_cs       = a_cs;
      acc_addr     = a_addr;
      acc_xfer     = a_xfer;
      acc_bus      = a_bus;
      cs           = a_cs;
      addr         = a_addr;
      xfer_size    = a_xfer;
      bus_size     = a_bus;
      valid_access = 1'b1;
      issued_cnt++;
      @(negedge sys_clk1);
      valid_access = 1'b0;
      assert (busy === 1'b1)
         else report_error("Busy did not rise in the cycle after valid_access");
   endtask

   initial
   begin
      valid_access = 1'b0;
      cs           = 1'b0;
      addr         = '0;
      xfer_size    = xsiz_8;
      bus_size     = bsiz_8;
      rnd_state    = 32'd49;
      test_name    = "reset";
      busy_cnt     = 0;
      issued_cnt   = 0;
      started_cnt  = 0;
      done_cnt     = 0;
      cycle_cnt    = 0;
      @(posedge n_sys_reset1);
      @(negedge sys_clk1);
      assert (smc_n_cs === 1'b1 && smc_n_be === 4'hF && busy === 1'b0 && smc_addr === '0)
         else report_error($sformatf(
            "FAIL reset: n_cs/n_be/busy/addr expected 1/f/0/0 actual %b/%h/%b/%h",
            smc_n_cs, smc_n_be, busy, smc_addr));

      // Every size pair at every byte offset
      test_name = "size_sweep";
      for (xi = 0; xi < 3; xi++)
         for (bi = 0; bi < 3; bi++)
            for (off = 0; off < 4; off++)
            begin
               rnd_state = xorshift(rnd_state);
               issue_access(1'b1, {rnd_state[31:2], off[1:0]},
                            smc_xfer_size_t'(xi), smc_bus_size_t'(bi));
            end

      // Deselected accesses
      test_name = "cs_low";
      issue_access(1'b0, 32'h0000_1003, xsiz_32, bsiz_8);
      issue_access(1'b0, 32'h0000_2002, xsiz_16, bsiz_32);
      issue_access(1'b0, 32'h0000_3001, xsiz_8, bsiz_16);

      test_name = "random";
      repeat (16)
      begin
         rnd_state = xorshift(rnd_state);
         issue_access(rnd_state[7:4] != 4'h0, xorshift(rnd_state ^ 32'h5a5a_0001),
                      smc_xfer_size_t'(rnd_state % 3), smc_bus_size_t'((rnd_state >> 8) % 3));
      end

      // Pulses during busy must be dropped
      test_name = "busy_pulse";
      issue_access(1'b1, 32'h1234_5679, xsiz_32, bsiz_8);
      cs           = 1'b0;
      addr         = 32'hedcb_a986;
      xfer_size    = xsiz_8;
      bus_size     = bsiz_32;
      valid_access = 1'b1;
      @(negedge sys_clk1);
      valid_access = 1'b0;
      issue_access(1'b1, 32'h0000_00fe, xsiz_16, bsiz_8);
      valid_access = 1'b1;                   // Extra pulse, still busy
      xfer_size    = xsiz_32;
      @(negedge sys_clk1);
      valid_access = 1'b0;

      while (busy)
         @(negedge sys_clk1);
      repeat (2) @(negedge sys_clk1);
      if (done_cnt != issued_cnt)
         report_error($sformatf("FAIL completion: accesses expected %0d actual %0d",
                                issued_cnt, done_cnt));
      else
      begin
         $display("all tests passed");
         $finish;
      end
   end

endmodule

// File: verilog.f
+incdir+source
source/smc_size_pkg.sv
source/smc_state_pkg.sv
source/smc_state.sv
source/smc_addr.sv
source/smc_lite.sv
testbench/smc_clk_gen.sv
testbench/tb_smc_lite.sv

// File: Bender.yml
package:
  name: smc_lite

export_include_dirs:
  - source

sources:
  - source/smc_size_pkg.sv
  - source/smc_state_pkg.sv
  - source/smc_state.sv
  - source/smc_addr.sv
  - source/smc_lite.sv
  - target: test
    files:
      - testbench/smc_clk_gen.sv
      - testbench/tb_smc_lite.sv
